// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_cpu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation PASSED
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "Result: pass"; \
	else echo "Result: fail, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: alu.sv
//================================================
// Combinational ALU: add, sub, and, or, inc and dec,
// with NZVC flags from a 9-bit sum
//================================================
`default_nettype none
`timescale 1ns/100ps

module alu import cpu_pkg::*; (
    input  wire alu_op_e op,
    input  wire word_t   a_val,
    input  wire word_t   b_val,
    output word_t        result,
    output flags_t       flags
);

    word_t           x;                        // Left operand of the adder
    word_t           y;                        // Right operand, B or the constant one
    logic            is_sub;
    logic            is_logic;
    logic [DATA_W:0] wide;                     // Top bit is carry or borrow
    logic            ovf;

    always_comb begin
        x        = a_val;
        y        = b_val;
        is_sub   = 1'b0;
        is_logic = 1'b0;
        case (op)
            ALU_SUB:         is_sub   = 1'b1;
            ALU_AND, ALU_OR: is_logic = 1'b1;
            ALU_INCA:        y        = word_t'(1);
            ALU_INCB: begin
                x = b_val;                     // INCB and DECB work on B alone
                y = word_t'(1);
            end
            ALU_DECA: begin
                y      = word_t'(1);
                is_sub = 1'b1;
            end
            ALU_DECB: begin
                x      = b_val;
                y      = word_t'(1);
                is_sub = 1'b1;
            end
            default: ;                         // ALU_ADD uses A and B as set above
        endcase
    end

    // Zero-extended subtraction sets bit DATA_W exactly when x < y unsigned
    assign wide = is_sub ? ({1'b0, x} - {1'b0, y}) : ({1'b0, x} + {1'b0, y});

    always_comb begin
        case (op)
            ALU_AND: result = a_val & b_val;
            ALU_OR:  result = a_val | b_val;
            default: result = wide[DATA_W-1:0];
        endcase
    end

    // Overflow when the sign of the result disagrees with what the operands allow
    assign ovf = (is_sub ? (x[DATA_W-1] ^ y[DATA_W-1]) : ~(x[DATA_W-1] ^ y[DATA_W-1]))
               & (result[DATA_W-1] ^ x[DATA_W-1]);

    assign flags.n = result[DATA_W-1];
    assign flags.z = (result == '0);
    assign flags.v = is_logic ? 1'b0 : ovf;    // Logic ops clear V and C
    assign flags.c = is_logic ? 1'b0 : wide[DATA_W];

endmodule

`default_nettype wire

// File: control_unit.sv
//================================================
// Multi-cycle Moore FSM of the CPU: fetch, decode and
// one execute sequence per opcode, each state a full control word
//================================================
`default_nettype none
`timescale 1ns/100ps

module control_unit import cpu_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire word_t  ir,                    // Opcode latched during fetch
    output ctrl_t       ctrl
);

    typedef enum logic [5:0] {
        S_FETCH_0, S_FETCH_1, S_FETCH_2,
        S_DECODE,
        S_LDA_IMM_0, S_LDA_IMM_1, S_LDA_IMM_2,
        S_LDA_DIR_0, S_LDA_DIR_1, S_LDA_DIR_2, S_LDA_DIR_3,
        S_LDB_IMM_0, S_LDB_IMM_1, S_LDB_IMM_2,
        S_LDB_DIR_0, S_LDB_DIR_1, S_LDB_DIR_2, S_LDB_DIR_3,
        S_STA_DIR_0, S_STA_DIR_1, S_STA_DIR_2, S_STA_DIR_3,
        S_STB_DIR_0, S_STB_DIR_1, S_STB_DIR_2, S_STB_DIR_3,
        S_ADD_AB, S_SUB_AB, S_AND_AB, S_OR_AB,
        S_INCA, S_INCB, S_DECA, S_DECB
    } state_e;

    state_e state, next_state;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) state <= S_FETCH_0;
        else        state <= next_state;
    end

    always_comb begin
        case (state)
            S_FETCH_0:   next_state = S_FETCH_1;
            S_FETCH_1:   next_state = S_FETCH_2;
            S_FETCH_2:   next_state = S_DECODE;
            S_DECODE: begin
                case (ir)
                    LDA_IMM: next_state = S_LDA_IMM_0;
                    LDA_DIR: next_state = S_LDA_DIR_0;
                    LDB_IMM: next_state = S_LDB_IMM_0;
                    LDB_DIR: next_state = S_LDB_DIR_0;
                    STA_DIR: next_state = S_STA_DIR_0;
                    STB_DIR: next_state = S_STB_DIR_0;
                    ADD_AB:  next_state = S_ADD_AB;
                    SUB_AB:  next_state = S_SUB_AB;
                    AND_AB:  next_state = S_AND_AB;
                    OR_AB:   next_state = S_OR_AB;
                    INCA:    next_state = S_INCA;
                    INCB:    next_state = S_INCB;
                    DECA:    next_state = S_DECA;
                    DECB:    next_state = S_DECB;
                    default: next_state = S_FETCH_0;   // Unknown byte acts as a no-op
                endcase
            end
            S_LDA_IMM_0: next_state = S_LDA_IMM_1;
            S_LDA_IMM_1: next_state = S_LDA_IMM_2;
            S_LDA_DIR_0: next_state = S_LDA_DIR_1;
            S_LDA_DIR_1: next_state = S_LDA_DIR_2;
            S_LDA_DIR_2: next_state = S_LDA_DIR_3;
            S_LDB_IMM_0: next_state = S_LDB_IMM_1;
            S_LDB_IMM_1: next_state = S_LDB_IMM_2;
            S_LDB_DIR_0: next_state = S_LDB_DIR_1;
            S_LDB_DIR_1: next_state = S_LDB_DIR_2;
            S_LDB_DIR_2: next_state = S_LDB_DIR_3;
            S_STA_DIR_0: next_state = S_STA_DIR_1;
            S_STA_DIR_1: next_state = S_STA_DIR_2;
            S_STA_DIR_2: next_state = S_STA_DIR_3;
            S_STB_DIR_0: next_state = S_STB_DIR_1;
            S_STB_DIR_1: next_state = S_STB_DIR_2;
            S_STB_DIR_2: next_state = S_STB_DIR_3;
            default:     next_state = S_FETCH_0;       // Last state of every sequence
        endcase
    end

    // Moore outputs, everything defaults to idle with the PC on the to-memory bus
    always_comb begin
        ctrl              = '0;
        ctrl.to_bus_sel   = TO_PC;
        ctrl.from_bus_sel = FROM_ALU;

        case (state)
            S_SUB_AB: ctrl.alu_sel = ALU_SUB;
            S_AND_AB: ctrl.alu_sel = ALU_AND;
            S_OR_AB:  ctrl.alu_sel = ALU_OR;
            S_INCA:   ctrl.alu_sel = ALU_INCA;
            S_INCB:   ctrl.alu_sel = ALU_INCB;
            S_DECA:   ctrl.alu_sel = ALU_DECA;
            S_DECB:   ctrl.alu_sel = ALU_DECB;
            default:  ctrl.alu_sel = ALU_ADD;
        endcase

        case (state)
            // PC goes to MAR through both buses, memory answers next cycle
            S_FETCH_0, S_LDA_IMM_0, S_LDA_DIR_0, S_LDB_IMM_0, S_LDB_DIR_0,
            S_STA_DIR_0, S_STB_DIR_0: begin
                ctrl.mar_load     = 1'b1;
                ctrl.from_bus_sel = FROM_TO_BUS;
            end
            // Step past the byte that MAR now points at
            S_FETCH_1, S_LDA_IMM_1, S_LDA_DIR_1, S_LDB_IMM_1, S_LDB_DIR_1,
            S_STA_DIR_1, S_STB_DIR_1: ctrl.pc_inc = 1'b1;
            S_FETCH_2: begin
                ctrl.ir_load      = 1'b1;
                ctrl.from_bus_sel = FROM_MEM;
            end
            // Operand byte is an address, so it goes back into MAR
            S_LDA_DIR_2, S_LDB_DIR_2, S_STA_DIR_2, S_STB_DIR_2: begin
                ctrl.mar_load     = 1'b1;
                ctrl.from_bus_sel = FROM_MEM;
            end
            S_LDA_IMM_2, S_LDA_DIR_3: begin
                ctrl.a_load       = 1'b1;
                ctrl.from_bus_sel = FROM_MEM;
            end
            S_LDB_IMM_2, S_LDB_DIR_3: begin
                ctrl.b_load       = 1'b1;
                ctrl.from_bus_sel = FROM_MEM;
            end
            S_STA_DIR_3: begin
                ctrl.write        = 1'b1;              // Only write cycle of the store
                ctrl.to_bus_sel   = TO_A;
            end
            S_STB_DIR_3: begin
                ctrl.write        = 1'b1;
                ctrl.to_bus_sel   = TO_B;
            end
            // Result lands in A and the flags in the CCR, the PC stays put
            S_ADD_AB, S_SUB_AB, S_AND_AB, S_OR_AB, S_INCA, S_DECA: begin
                ctrl.a_load       = 1'b1;
                ctrl.ccr_load     = 1'b1;
            end
            S_INCB, S_DECB: begin
                ctrl.b_load       = 1'b1;
                ctrl.ccr_load     = 1'b1;
            end
            default: ;                                 // Decode only looks at IR
        endcase
    end

endmodule

`default_nettype wire

// File: cpu_checker.sv
//================================================
// Concurrent checks on the CPU memory port
// Bound into cpu_top by the bind after the module
//================================================
`default_nettype none
`timescale 1ns/100ps

module cpu_checker import cpu_pkg::*; (
    input wire        clk,
    input wire        reset,
    input wire        mem_write,
    input wire addr_t mem_addr,
    input wire ctrl_t ctrl
);

    logic pc_to_mar;                           // MAR takes the PC through both buses

    assign pc_to_mar = ctrl.mar_load && ctrl.from_bus_sel == FROM_TO_BUS
                       && ctrl.to_bus_sel == TO_PC;

    // Port stays quiet and MAR stays cleared while reset holds
    quiet_in_reset: assert property (@(posedge clk) !reset |-> !mem_write && mem_addr == '0)
        else $error("memory port active during reset");

    single_write: assert property (@(posedge clk) disable iff (!reset)
        mem_write |=> !mem_write)
        else $error("mem_write high for two cycles in a row");

    // A store loads MAR from the PC, steps the PC, reloads MAR, then writes
    write_after_store_seq: assert property (@(posedge clk) disable iff (!reset)
        mem_write |-> $past(pc_to_mar, 3))
        else $error("write without a store sequence before it");

endmodule

bind cpu_top cpu_checker checker_i (
    .clk       (clk),
    .reset     (reset),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .ctrl      (ctrl)
);

`default_nettype wire

// File: cpu_pkg.sv
//================================================
// Shared widths, opcodes, bus selects and the control
// and flag structs of the 8-bit accumulator CPU
// Every design file pulls this in with a wildcard import
//================================================
`default_nettype none

package cpu_pkg;

    localparam int DATA_W = 8;                 // Width of A, B, IR and the memory data
    localparam int ADDR_W = 8;                 // Width of PC, MAR and the memory address

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Instruction set as it sits in memory, one opcode byte per instruction
    typedef enum logic [7:0] {
        LDA_IMM = 8'h10,                       // A <= next byte
        LDA_DIR = 8'h11,                       // A <= mem[next byte]
        LDB_IMM = 8'h12,                       // B <= next byte
        LDB_DIR = 8'h13,                       // B <= mem[next byte]
        STA_DIR = 8'h14,                       // mem[next byte] <= A
        STB_DIR = 8'h15,                       // mem[next byte] <= B
        ADD_AB  = 8'h20,                       // A <= A + B
        SUB_AB  = 8'h21,                       // A <= A - B
        AND_AB  = 8'h22,                       // A <= A & B
        OR_AB   = 8'h23,                       // A <= A | B
        INCA    = 8'h24,
        INCB    = 8'h25,
        DECA    = 8'h26,
        DECB    = 8'h27
    } opcode_e;

    // ALU function select, the order matches the low bits of the ALU opcodes
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_AND  = 3'd2,
        ALU_OR   = 3'd3,
        ALU_INCA = 3'd4,
        ALU_INCB = 3'd5,
        ALU_DECA = 3'd6,
        ALU_DECB = 3'd7
    } alu_op_e;

    // Source of the to-memory bus, which also drives the write data
    typedef enum logic [1:0] {
        TO_PC = 2'b00,
        TO_A  = 2'b01,
        TO_B  = 2'b10
    } to_bus_e;

    // Source of the from-memory bus that feeds MAR, IR, A and B
    typedef enum logic [1:0] {
        FROM_ALU    = 2'b00,
        FROM_TO_BUS = 2'b01,
        FROM_MEM    = 2'b10
    } from_bus_e;

    // One control word per FSM state
    typedef struct packed {
        logic      ir_load;
        logic      ccr_load;
        logic      mar_load;
        logic      pc_inc;
        logic      a_load;
        logic      b_load;
        logic      write;                      // Memory write strobe
        alu_op_e   alu_sel;
        to_bus_e   to_bus_sel;
        from_bus_e from_bus_sel;
    } ctrl_t;

    // Condition codes in the usual NZVC order
    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } flags_t;

endpackage

`default_nettype wire

// File: cpu_top.sv
//================================================
// Top level of the accumulator CPU, control unit plus datapath
// Memory lives outside and reads combinationally from mem_addr
//================================================
`default_nettype none
`timescale 1ns/100ps

module cpu_top import cpu_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire word_t  mem_rdata,
    output addr_t       mem_addr,              // Driven straight from MAR
    output word_t       mem_wdata,
    output logic        mem_write,             // Written at the clock edge while high
    output flags_t      ccr
);

    ctrl_t ctrl;                               // Control word of the current FSM state
    word_t ir;

    control_unit control_unit_i (
        .clk   (clk),
        .reset (reset),
        .ir    (ir),
        .ctrl  (ctrl)
    );

    datapath datapath_i (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_rdata (mem_rdata),
        .ir        (ir),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .ccr       (ccr)
    );

    assign mem_write = ctrl.write;

endmodule

`default_nettype wire

// File: datapath.sv
//================================================
// Register datapath: PC, MAR, IR, A, B and CCR around
// the to-memory and from-memory buses, steered by the control word
//================================================
`default_nettype none
`timescale 1ns/100ps

module datapath import cpu_pkg::*; (
    input  wire         clk,
    input  wire         reset,
    input  wire ctrl_t  ctrl,
    input  wire word_t  mem_rdata,             // Combinational read of mem[mem_addr]
    output word_t       ir,
    output addr_t       mem_addr,
    output word_t       mem_wdata,
    output flags_t      ccr
);

    addr_t  pc;
    addr_t  mar;
    word_t  a_reg;
    word_t  b_reg;
    word_t  to_bus;                            // PC, A or B toward memory
    word_t  from_bus;                          // ALU, to-memory bus or memory toward the registers
    word_t  alu_result;
    flags_t alu_flags;

    // Data and address are both 8 bits, so the PC drops onto the data bus as is
    always_comb begin
        case (ctrl.to_bus_sel)
            TO_A:    to_bus = a_reg;
            TO_B:    to_bus = b_reg;
            default: to_bus = pc;
        endcase
    end

    always_comb begin
        case (ctrl.from_bus_sel)
            FROM_TO_BUS: from_bus = to_bus;
            FROM_MEM:    from_bus = mem_rdata;
            default:     from_bus = alu_result;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;                          // Programs start at address 0
        end else if (ctrl.pc_inc) begin
            pc <= pc + addr_t'(1);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mar <= '0;
            ir  <= '0;
        end else begin
            if (ctrl.mar_load) mar <= addr_t'(from_bus);   // Either the PC or a direct address
            if (ctrl.ir_load)  ir  <= from_bus;
        end
    end

    // Accumulators take memory bytes on loads and ALU results on arithmetic
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            a_reg <= '0;
            b_reg <= '0;
        end else begin
            if (ctrl.a_load) a_reg <= from_bus;
            if (ctrl.b_load) b_reg <= from_bus;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)             ccr <= '0;
        else if (ctrl.ccr_load) ccr <= alu_flags;  // Only ALU states touch the flags
    end

    alu alu_i (
        .op     (ctrl.alu_sel),
        .a_val  (a_reg),
        .b_val  (b_reg),
        .result (alu_result),
        .flags  (alu_flags)
    );

    assign mem_addr  = mar;
    assign mem_wdata = to_bus;                 // Memory only samples this while write is high

endmodule

`default_nettype wire

// File: project.f
cpu_pkg.sv
alu.sv
datapath.sv
control_unit.sv
cpu_top.sv
cpu_checker.sv
tb_cpu.sv

// File: tb_cpu.sv
//================================================
// Testbench for the accumulator CPU with clock, reset and memory model
// Builds a program at address 0 and predicts each store with a model
//================================================
`default_nettype none
`timescale 1ns/100ps

module tb_cpu import cpu_pkg::*; ;

    typedef struct packed {
        addr_t  addr;
        word_t  data;
        flags_t flags;                         // CCR expected while the write is on the port
    } store_t;

    typedef struct packed {
        word_t  value;
        flags_t flags;
    } alu_out_t;

    logic   clk;
    logic   reset;
    word_t  mem_rdata;
    addr_t  mem_addr;
    word_t  mem_wdata;
    logic   mem_write;
    flags_t ccr;

    word_t  mem   [256];                       // Memory seen by the DUT
    word_t  image [256];                       // Program and data copied in during reset
    store_t expected_q [$];
    addr_t  prog_addr;
    addr_t  store_addr;
    word_t  model_a;
    word_t  model_b;
    flags_t model_ccr;
    int     writes_seen;
    int     total;

    cpu_top dut_i (
        .clk       (clk),
        .reset     (reset),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_write (mem_write),
        .ccr       (ccr)
    );

    always #20 clk = ~clk;

    assign mem_rdata = mem[mem_addr];          // Reads answer in the same cycle

    always @(posedge clk or negedge reset) begin
        if (!reset)         mem <= image;
        else if (mem_write) mem[mem_addr] <= mem_wdata;
    end

    task automatic value_error(input string name, input word_t expected, input word_t actual);
        $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
        $display("Simulation FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    // Sign of an 8-bit pattern taken as two's complement
    function automatic int as_signed(input int x);
        return (x > 127) ? x - 256 : x;
    endfunction

    // Expected result and flags of one ALU instruction
    function automatic alu_out_t alu_ref(input opcode_e op, input word_t a, input word_t b);
        alu_out_t o;
        int       lhs;
        int       rhs;
        int       full;
        int       sgn;
        bit       is_sub;
        lhs    = int'(a);
        rhs    = int'(b);
        is_sub = 1'b0;
        case (op)
            SUB_AB: is_sub = 1'b1;
            INCA:   rhs = 1;
            INCB: begin
                lhs = int'(b);
                rhs = 1;
            end
            DECA: begin
                rhs    = 1;
                is_sub = 1'b1;
            end
            DECB: begin
                lhs    = int'(b);
                rhs    = 1;
                is_sub = 1'b1;
            end
            default: ;
        endcase
        full      = is_sub ? lhs - rhs : lhs + rhs;
        sgn       = is_sub ? as_signed(lhs) - as_signed(rhs) : as_signed(lhs) + as_signed(rhs);
        o.value   = word_t'(full & 255);
        o.flags.c = is_sub ? (lhs < rhs) : (full > 255);   // Borrow or carry out
        o.flags.v = (sgn > 127) || (sgn < -128);
        if (op == AND_AB || op == OR_AB) begin
            o.value   = (op == AND_AB) ? (a & b) : (a | b);
            o.flags.c = 1'b0;
            o.flags.v = 1'b0;
        end
        o.flags.n = o.value[7];
        o.flags.z = (o.value == '0);
        return o;
    endfunction

    task automatic emit_byte(input word_t value);
        image[prog_addr] = value;
        prog_addr        = prog_addr + addr_t'(1);
    endtask

    task automatic load_immediate(input bit to_b, input word_t value);
        emit_byte(to_b ? LDB_IMM : LDA_IMM);
        emit_byte(value);
        if (to_b) model_b = value;
        else      model_a = value;
    endtask

    task automatic fetch_direct(input bit to_b, input addr_t addr);
        emit_byte(to_b ? LDB_DIR : LDA_DIR);
        emit_byte(addr);
        if (to_b) model_b = image[addr];       // Data area is filled before the loads
        else      model_a = image[addr];
    endtask

    // Each store gets the next free byte of the store area
    task automatic store_reg(input bit from_b);
        store_t entry;
        emit_byte(from_b ? STB_DIR : STA_DIR);
        emit_byte(store_addr);
        entry.addr  = store_addr;
        entry.data  = from_b ? model_b : model_a;
        entry.flags = model_ccr;
        expected_q.push_back(entry);
        store_addr = store_addr + addr_t'(1);
    endtask

    task automatic apply_alu(input opcode_e op);
        alu_out_t res;
        emit_byte(op);
        res = alu_ref(op, model_a, model_b);
        if (op == INCB || op == DECB) model_b = res.value;
        else                          model_a = res.value;
        model_ccr = res.flags;
    endtask

    task automatic run_alu_case(input opcode_e op, input word_t a, input word_t b);
        load_immediate(1'b0, a);
        load_immediate(1'b1, b);
        apply_alu(op);
        store_reg(op == INCB || op == DECB);   // Store whichever register took the result
    endtask

    task automatic build_program();
        word_t same;
        for (int i = 0; i < 256; i++) begin
            image[i] = word_t'(i) ^ 8'hA5;     // Background byte differs at every address
        end
        prog_addr  = '0;
        store_addr = 8'hC0;
        model_a    = '0;
        model_b    = '0;
        model_ccr  = '0;
        image[8'h80] = word_t'($urandom);
        image[8'h81] = word_t'($urandom);
        load_immediate(1'b0, word_t'($urandom));
        load_immediate(1'b1, word_t'($urandom));
        store_reg(1'b0);
        store_reg(1'b1);
        emit_byte(8'hFF);                      // Not an opcode so decode drops back to fetch
        fetch_direct(1'b0, 8'h80);
        fetch_direct(1'b1, 8'h81);
        store_reg(1'b1);
        store_reg(1'b0);
        emit_byte(8'h3A);
        run_alu_case(ADD_AB, word_t'($urandom), word_t'($urandom));
        run_alu_case(SUB_AB, word_t'($urandom), word_t'($urandom));
        run_alu_case(AND_AB, word_t'($urandom), word_t'($urandom));
        run_alu_case(OR_AB,  word_t'($urandom), word_t'($urandom));
        run_alu_case(INCA,   word_t'($urandom), word_t'($urandom));
        emit_byte(8'h16);
        run_alu_case(INCB,   word_t'($urandom), word_t'($urandom));
        run_alu_case(DECA,   word_t'($urandom), word_t'($urandom));
        run_alu_case(DECB,   word_t'($urandom), word_t'($urandom));
        emit_byte(8'h00);
        same = word_t'($urandom);
        run_alu_case(ADD_AB, 8'h7F, 8'h01);    // Signed overflow into the sign bit
        run_alu_case(DECA,   8'h00, word_t'($urandom));
        run_alu_case(SUB_AB, same, same);      // Equal operands give zero
        run_alu_case(INCB,   word_t'($urandom), 8'hFF);
    endtask

    // Each write on the port must match the oldest expected store
    always @(negedge clk) begin : check_port
        store_t want;
        if (!reset) begin
            assert (mem_write == 1'b0) else value_error("mem_write", 8'h00, {7'h0, mem_write});
            assert (mem_addr == '0) else value_error("mem_addr", 8'h00, mem_addr);
        end else if (mem_write) begin
            if (expected_q.size() == 0) begin
                $display("Memory write to %0h at t=%0t with no store left", mem_addr, $time);
                $display("Simulation FAILED");
                $fatal(1, "unexpected write");
            end else begin
                want = expected_q.pop_front();
                assert (mem_addr == want.addr) else value_error("mem_addr", want.addr, mem_addr);
                assert (mem_wdata == want.data)
                    else value_error("mem_wdata", want.data, mem_wdata);
                assert (ccr == want.flags)
                    else value_error("ccr", {4'h0, want.flags}, {4'h0, ccr});
                writes_seen = writes_seen + 1;
            end
        end
    end

    task automatic wait_for_write(input int count, input int max_cycles);
        int cycles;
        cycles = 0;
        while (writes_seen < count && cycles < max_cycles) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (writes_seen < count) begin
            $display("Timeout: store %0d never came within %0d cycles", count, max_cycles);
            $display("Simulation FAILED");
            $fatal(1, "store missing");
        end
    endtask

    initial begin
        void'($urandom(84));
        clk         = 1'b0;
        reset       = 1'b1;
        writes_seen = 0;
        build_program();
        #2 reset = 1'b0;
        repeat (16) @(posedge clk);
        #2 reset = 1'b1;
        total = expected_q.size();
        for (int i = 1; i <= total; i++) begin
            wait_for_write(i, 100);            // Longest gap is a few instructions plus a no-op
        end
        if (expected_q.size() == 0 && writes_seen == total) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Stores left unchecked at the end of the run: %0d", expected_q.size());
            $display("Simulation FAILED");
            $fatal(1, "run ended early");
        end
    end

endmodule

`default_nettype wire
